/* Makefile */
TOP := tb_tpu_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_tpu_core.sv */
`timescale 1ns/10ps

module tb_tpu_core
    import tpu_pkg::*;
();

    logic        clk_i;
    logic        rst_n_i;
    logic        ub_we_i;
    ub_addr_t    ub_waddr_i;
    operand_t    ub_wdata_i;
    logic        instr_we_i;
    instr_word_t instr_i;
    logic        iq_empty_o;
    logic        iq_full_o;
    logic        busy_o;
    logic        result_valid_o;
    mac_result_t result_o;

    operand_t ub_mirror [UB_DEPTH];  // Host view of the buffer
    acc_t     exp_value [$];
    ub_addr_t exp_addr  [$];
    int       error_cnt;

    tpu_core u_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ub_we_i        (ub_we_i),
        .ub_waddr_i     (ub_waddr_i),
        .ub_wdata_i     (ub_wdata_i),
        .instr_we_i     (instr_we_i),
        .instr_i        (instr_i),
        .iq_empty_o     (iq_empty_o),
        .iq_full_o      (iq_full_o),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    bind tpu_core tpu_core_chk u_chk (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .iq_empty_i     (iq_empty_o),
        .iq_full_i      (iq_full_o),
        .pop_i          (pop),
        .busy_i         (busy_o),
        .result_valid_i (result_valid_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_equal(input string what, input longint actual, input longint expected);
        if (actual !== expected) begin
            error_cnt++;
            $display("** Error @ %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            stop_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic add_expected(input instr_word_t word);
        int v_dim;
        int u_dim;
        int rd;
        int wr;
        int sum;
        v_dim = int'(word[11:4]);
        u_dim = int'(word[19:12]);
        rd    = int'(word[39:28]);
        wr    = int'(word[51:40]);
        for (int u = 0; u < u_dim; u++) begin
            sum = 0;
            for (int v = 0; v < v_dim; v++) begin
                // Row-major A, shared W right after the matrix
                sum += int'(ub_mirror[(rd + u * v_dim + v) % UB_DEPTH])
                     * int'(ub_mirror[(rd + u_dim * v_dim + v) % UB_DEPTH]);
            end
            exp_value.push_back(acc_t'(sum));
            exp_addr.push_back(ub_addr_t'((wr + u) % UB_DEPTH));
        end
    endtask

    function automatic instr_word_t make_mac(input int v_dim, input int u_dim,
                                            input int rd, input int wr);
        instr_word_t word;
        word        = {$urandom, $urandom};  // Ignored fields carry noise
        word[3:0]   = OP_MAC;
        word[11:4]  = 8'(v_dim);
        word[19:12] = 8'(u_dim);
        word[39:28] = 12'(rd);
        word[51:40] = 12'(wr);
        return word;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_operand(input int addr, input operand_t data);
        @(posedge clk_i);
        #1;
        ub_we_i    = 1'b1;
        ub_waddr_i = ub_addr_t'(addr);
        ub_wdata_i = data;
        ub_mirror[addr % UB_DEPTH] = data;
    endtask

    task automatic push_instr(input instr_word_t word, inout int accepted);
        @(posedge clk_i);
        #1;
        instr_we_i = 1'b1;
        instr_i    = word;
        if (word[3:0] == OP_MAC && !iq_full_o) begin  // Full queue drops the word
            accepted++;
            add_expected(word);
        end
    endtask

    task automatic push_random_mac(inout int accepted);
        int v_dim;
        int u_dim;
        int rd;
        int wr;
        v_dim = $urandom_range(1, 6);
        u_dim = $urandom_range(1, 6);
        rd    = $urandom_range(0, 200);
        wr    = $urandom_range(0, UB_DEPTH - 1);
        push_instr(make_mac(v_dim, u_dim, rd, wr), accepted);
    endtask

    task automatic release_inputs();
        @(posedge clk_i);
        #1;
        ub_we_i    = 1'b0;
        instr_we_i = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_value.size() != 0) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: %0d rows still missing after %0d cycles",
                         exp_value.size(), limit);
                stop_run();
            end
        end
    endtask

    task automatic wait_running(input int limit);
        int cycles;
        cycles = 0;
        while (!(busy_o && iq_empty_o)) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: sequencer never took the first instruction");
                stop_run();
            end
        end
    endtask

    // Result monitor, sampled away from the active edge
    always @(negedge clk_i) begin
        if (rst_n_i && result_valid_o) begin
            if (exp_value.size() == 0) begin
                $display("Unexpected result for address %0d with no row pending",
                         result_o.addr);
                stop_run();
            end else begin
                check_equal("result value", result_o.value, exp_value.pop_front());
                check_equal("result address", result_o.addr, exp_addr.pop_front());
            end
        end
    end

    initial begin
        int          accepted;
        int          op;
        instr_word_t word;
        void'($urandom(89002));
        error_cnt  = 0;
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        ub_we_i    = 1'b0;
        ub_waddr_i = '0;
        ub_wdata_i = '0;
        instr_we_i = 1'b0;
        instr_i    = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        // Reset values
        check_equal("iq_empty_o after reset", iq_empty_o, 1);
        check_equal("iq_full_o after reset", iq_full_o, 0);
        check_equal("busy_o after reset", busy_o, 0);
        check_equal("result_valid_o after reset", result_valid_o, 0);
        repeat (10) @(posedge clk_i);

        for (int i = 0; i < 256; i++) begin
            write_operand(i, operand_t'($urandom));
        end
        release_inputs();

        // Single random instructions
        repeat (12) begin
            accepted = 0;
            push_random_mac(accepted);
            release_inputs();
            check_equal("accepted MAC words", accepted, 1);
            wait_drain(2000);
        end

        // Back-to-back queue, FIFO order
        accepted = 0;
        repeat (8) push_random_mac(accepted);
        release_inputs();
        check_equal("accepted MAC words", accepted, 8);
        wait_drain(5000);

        // Non-MAC opcodes are dropped
        accepted = 0;
        repeat (6) begin
            word = {$urandom, $urandom};
            op   = $urandom_range(0, 14);
            if (op != 0) op++;
            word[3:0] = 4'(op);
            push_instr(word, accepted);
            check_equal("iq_empty_o during non-MAC words", iq_empty_o, 1);
        end
        release_inputs();
        check_equal("iq_empty_o after non-MAC words", iq_empty_o, 1);
        check_equal("busy_o after non-MAC words", busy_o, 0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Fill the queue behind a long instruction
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        accepted = 0;
        push_instr(make_mac(6, 6, $urandom_range(0, 200), $urandom_range(0, 4095)), accepted);
        release_inputs();
        wait_running(100);
        accepted = 0;
        repeat (IQ_DEPTH + 1) push_random_mac(accepted);
        release_inputs();
        check_equal("accepted words into a full queue", accepted, IQ_DEPTH);
        check_equal("iq_full_o with 32 outstanding", iq_full_o, 1);
        wait_drain(20000);

        // Edge dimensions and extreme operands
        for (int i = 512; i < 576; i++) begin
            write_operand(i, (i < 544) ? -8'sd128 : 8'sd127);
        end
        release_inputs();
        accepted = 0;
        push_instr(make_mac(1, 1, 512, 100), accepted);
        push_instr(make_mac(6, 1, 512, 200), accepted);
        push_instr(make_mac(1, 6, 538, 4093), accepted);  // Row address wraps
        push_instr(make_mac(6, 6, 512, 4090), accepted);
        release_inputs();
        wait_drain(5000);
        check_equal("busy_o after drain", busy_o, 0);
        check_equal("iq_empty_o after drain", iq_empty_o, 1);

        if (error_cnt == 0 && exp_value.size() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* bench/tpu_core_chk.sv */
`timescale 1ns/10ps

module tpu_core_chk (
    input logic clk_i,
    input logic rst_n_i,
    input logic iq_empty_i,
    input logic iq_full_i,
    input logic pop_i,
    input logic busy_i,
    input logic result_valid_i
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    flags_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(iq_empty_i && iq_full_i))
        else $error("Queue flags empty and full are high together");

    pop_clears_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |=> !iq_full_i)
        else $error("Queue still full after a pop");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer and MAC
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pop_starts_seq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |=> (busy_i && !pop_i))
        else $error("Sequencer not busy or popped again after a pop");

    result_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i |=> !result_valid_i)
        else $error("Result valid held for more than one cycle");  // One pulse per row

endmodule

/* flist.f */
hdl/tpu_pkg.sv
hdl/instr_queue.sv
hdl/unified_buffer.sv
hdl/mac_sequencer.sv
hdl/mac_unit.sv
hdl/tpu_core.sv
bench/tpu_core_chk.sv
bench/tb_tpu_core.sv

/* hdl/instr_queue.sv */
`timescale 1ns/10ps

module instr_queue
    import tpu_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  instr_word_t    instr_i,
    input  logic           write_i,
    input  logic           read_i,
    output logic           iq_empty_o,
    output logic           iq_full_o,
    output decoded_instr_t decoded_o
);

    typedef enum logic [1:0] {IQ_EMPTY, IQ_STEADY, IQ_FULL} iq_state_e;

    iq_state_e      state_q;
    decoded_instr_t fifo_q [IQ_DEPTH];
    decoded_instr_t dec;
    iq_idx_t        wr_ptr_q;
    iq_idx_t        rd_ptr_q;
    iq_idx_t        wr_ptr_nxt;
    iq_idx_t        rd_ptr_nxt;
    logic           push;
    logic           pop;

    // Field extraction for MAC words
    always_comb begin
        dec.v_dim    = dim_t'(instr_i[11:4]);
        dec.u_dim    = dim_t'(instr_i[19:12]);
        dec.v_dim_m1 = dim_t'(instr_i[11:4] - 8'd1);
        dec.u_dim_m1 = dim_t'(instr_i[19:12] - 8'd1);
        dec.rd_addr  = ub_addr_t'(instr_i[39:28]);
        dec.wr_addr  = ub_addr_t'(instr_i[51:40]);
    end

    assign push = write_i && (opcode_e'(instr_i[3:0]) == OP_MAC) && !iq_full_o;
    assign pop  = read_i && !iq_empty_o;

    assign wr_ptr_nxt = push ? wr_ptr_q + 1'b1 : wr_ptr_q;
    assign rd_ptr_nxt = pop  ? rd_ptr_q + 1'b1 : rd_ptr_q;

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= dec;
        end
        if (pop) begin
            decoded_o <= fifo_q[rd_ptr_q];  // Valid the cycle after pop
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IQ_EMPTY;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            iq_empty_o <= 1'b1;
            iq_full_o  <= 1'b0;
        end else begin
            wr_ptr_q <= wr_ptr_nxt;
            rd_ptr_q <= rd_ptr_nxt;
            case (state_q)
                IQ_EMPTY: begin
                    if (push) begin
                        iq_empty_o <= 1'b0;
                        state_q    <= IQ_STEADY;
                    end
                end
                IQ_STEADY: begin
                    // Push and pop together keep the count
                    if (push && !pop && (wr_ptr_nxt == rd_ptr_q)) begin
                        iq_full_o <= 1'b1;
                        state_q   <= IQ_FULL;
                    end else if (pop && !push && (rd_ptr_nxt == wr_ptr_q)) begin
                        iq_empty_o <= 1'b1;
                        state_q    <= IQ_EMPTY;
                    end
                end
                IQ_FULL: begin
                    if (pop) begin
                        iq_full_o <= 1'b0;
                        state_q   <= IQ_STEADY;
                    end
                end
                default: begin
                    state_q <= IQ_EMPTY;
                end
            endcase
        end
    end

endmodule

/* hdl/mac_sequencer.sv */
`timescale 1ns/10ps

module mac_sequencer
    import tpu_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  logic           iq_empty_i,
    output logic           pop_o,
    input  decoded_instr_t instr_i,
    output ub_addr_t       ub_raddr_o,
    output logic           op_valid_o,
    output logic           a_sel_o,
    output logic           first_o,
    output logic           last_o,
    output ub_addr_t       row_addr_o,
    output logic           busy_o
);

    typedef enum logic [1:0] {SQ_IDLE, SQ_POP, SQ_LOAD, SQ_RUN} sq_state_e;

    sq_state_e      state_q;
    decoded_instr_t instr_q;
    ub_addr_t       a_addr_q;
    ub_addr_t       w_addr_q;
    ub_addr_t       w_base_q;
    ub_addr_t       row_q;
    ub_addr_t       w_start;
    dim_t           v_cnt_q;
    dim_t           u_cnt_q;
    logic           a_phase_q;
    logic           running;
    logic           elem_first;
    logic           elem_last;
    logic           instr_done;

    assign running    = (state_q == SQ_RUN);
    assign pop_o      = (state_q == SQ_IDLE) && !iq_empty_i;
    assign busy_o     = (state_q != SQ_IDLE);

    // W vector sits right after the U x V matrix
    assign w_start    = instr_q.rd_addr + ub_addr_t'(instr_q.u_dim) * ub_addr_t'(instr_q.v_dim);

    assign elem_first = (v_cnt_q == '0);
    assign elem_last  = (v_cnt_q == instr_q.v_dim_m1);
    assign instr_done = !a_phase_q && elem_last && (u_cnt_q == instr_q.u_dim_m1);

    assign ub_raddr_o = a_phase_q ? a_addr_q : w_addr_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Loop control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= SQ_IDLE;
            a_phase_q <= 1'b1;
            v_cnt_q   <= '0;
            u_cnt_q   <= '0;
        end else begin
            case (state_q)
                SQ_IDLE: begin
                    if (pop_o) state_q <= SQ_POP;
                end
                SQ_POP: begin
                    state_q <= SQ_LOAD;  // Queue output lands this cycle
                end
                SQ_LOAD: begin
                    v_cnt_q   <= '0;
                    u_cnt_q   <= '0;
                    a_phase_q <= 1'b1;
                    state_q   <= SQ_RUN;
                end
                SQ_RUN: begin
                    a_phase_q <= !a_phase_q;
                    if (!a_phase_q) begin
                        if (elem_last) begin
                            v_cnt_q <= '0;
                            u_cnt_q <= u_cnt_q + 8'd1;
                        end else begin
                            v_cnt_q <= v_cnt_q + 8'd1;
                        end
                        if (instr_done) state_q <= SQ_IDLE;
                    end
                end
                default: begin
                    state_q <= SQ_IDLE;
                end
            endcase
        end
    end

    // Address walk, A is row-major so it just increments
    always_ff @(posedge clk_i) begin
        if (state_q == SQ_POP) begin
            instr_q <= instr_i;
        end
        if (state_q == SQ_LOAD) begin
            a_addr_q <= instr_q.rd_addr;
            w_base_q <= w_start;
            w_addr_q <= w_start;
            row_q    <= instr_q.wr_addr;
        end else if (running) begin
            if (a_phase_q) begin
                a_addr_q <= a_addr_q + 1'b1;
            end else if (elem_last) begin
                w_addr_q <= w_base_q;    // Rewind W for next row
                row_q    <= row_q + 1'b1;
            end else begin
                w_addr_q <= w_addr_q + 1'b1;
            end
        end
        row_addr_o <= row_q;
    end

    // Control delayed to line up with buffer data
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            op_valid_o <= 1'b0;
            a_sel_o    <= 1'b0;
            first_o    <= 1'b0;
            last_o     <= 1'b0;
        end else begin
            op_valid_o <= running;
            a_sel_o    <= running && a_phase_q;
            first_o    <= running && elem_first;
            last_o     <= running && elem_last;
        end
    end

endmodule

/* hdl/mac_unit.sv */
`timescale 1ns/10ps

module mac_unit
    import tpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        op_valid_i,
    input  logic        a_sel_i,
    input  logic        first_i,
    input  logic        last_i,
    input  operand_t    data_i,
    input  ub_addr_t    row_addr_i,
    output logic        result_valid_o,
    output mac_result_t result_o
);

    operand_t a_hold_q;
    acc_t     prod_q;
    acc_t     acc_q;
    ub_addr_t prod_row_q;
    ub_addr_t acc_row_q;
    logic     prod_first_q;
    logic     prod_last_q;
    logic     prod_valid_q;
    logic     acc_done_q;
    logic     w_beat;

    assign w_beat = op_valid_i && !a_sel_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiply, accumulate, output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (op_valid_i && a_sel_i) begin
            a_hold_q <= data_i;  // Wait for W partner
        end
        if (w_beat) begin
            prod_q       <= acc_t'(a_hold_q) * acc_t'(data_i);
            prod_first_q <= first_i;
            prod_last_q  <= last_i;
            prod_row_q   <= row_addr_i;
        end
        if (prod_valid_q) begin
            acc_q     <= prod_first_q ? prod_q : acc_q + prod_q;
            acc_row_q <= prod_row_q;
        end
        if (acc_done_q) begin
            result_o.value <= acc_q;
            result_o.addr  <= acc_row_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prod_valid_q   <= 1'b0;
            acc_done_q     <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            prod_valid_q   <= w_beat;
            acc_done_q     <= prod_valid_q && prod_last_q;
            result_valid_o <= acc_done_q;  // Single pulse per row
        end
    end

endmodule

/* hdl/tpu_core.sv */
`timescale 1ns/10ps

module tpu_core
    import tpu_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        ub_we_i,
    input  ub_addr_t    ub_waddr_i,
    input  operand_t    ub_wdata_i,
    input  logic        instr_we_i,
    input  instr_word_t instr_i,
    output logic        iq_empty_o,
    output logic        iq_full_o,
    output logic        busy_o,
    output logic        result_valid_o,
    output mac_result_t result_o
);

    decoded_instr_t decoded;
    ub_addr_t       ub_raddr;
    ub_addr_t       row_addr;
    operand_t       ub_rdata;
    logic           pop;
    logic           op_valid;
    logic           a_sel;
    logic           first;
    logic           last;

    instr_queue u_queue (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .instr_i    (instr_i),
        .write_i    (instr_we_i),
        .read_i     (pop),
        .iq_empty_o (iq_empty_o),
        .iq_full_o  (iq_full_o),
        .decoded_o  (decoded)
    );

    mac_sequencer u_seq (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .iq_empty_i (iq_empty_o),
        .pop_o      (pop),
        .instr_i    (decoded),
        .ub_raddr_o (ub_raddr),
        .op_valid_o (op_valid),
        .a_sel_o    (a_sel),
        .first_o    (first),
        .last_o     (last),
        .row_addr_o (row_addr),
        .busy_o     (busy_o)
    );

    // Host owns the write port, sequencer the read port
    unified_buffer u_ub (
        .clk_i   (clk_i),
        .we_i    (ub_we_i),
        .waddr_i (ub_waddr_i),
        .wdata_i (ub_wdata_i),
        .raddr_i (ub_raddr),
        .rdata_o (ub_rdata)
    );

    mac_unit u_mac (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .op_valid_i     (op_valid),
        .a_sel_i        (a_sel),
        .first_i        (first),
        .last_i         (last),
        .data_i         (ub_rdata),
        .row_addr_i     (row_addr),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

/* hdl/tpu_pkg.sv */
package tpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int INSTR_W   = 64;
    localparam int IQ_DEPTH  = 32;
    localparam int IQ_IDX_W  = 5;
    localparam int UB_DEPTH  = 4096;
    localparam int UB_ADDR_W = 12;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word layout: [3:0] opcode, [11:4] V_dim, [19:12] U_dim,
    // [39:28] read address, [51:40] write address
    typedef logic [INSTR_W-1:0]   instr_word_t;
    typedef logic [IQ_IDX_W-1:0]  iq_idx_t;
    typedef logic [7:0]           dim_t;
    typedef logic [UB_ADDR_W-1:0] ub_addr_t;
    typedef logic signed [7:0]    operand_t;
    typedef logic signed [31:0]   acc_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_MAC = 4'd1
    } opcode_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Structs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        dim_t     v_dim;
        dim_t     u_dim;
        dim_t     v_dim_m1;    // Loop bounds, precomputed at decode
        dim_t     u_dim_m1;
        ub_addr_t rd_addr;
        ub_addr_t wr_addr;
    } decoded_instr_t;

    typedef struct packed {
        acc_t     value;
        ub_addr_t addr;
    } mac_result_t;

endpackage

/* hdl/unified_buffer.sv */
`timescale 1ns/10ps

module unified_buffer
    import tpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     we_i,
    input  ub_addr_t waddr_i,
    input  operand_t wdata_i,
    input  ub_addr_t raddr_i,
    output operand_t rdata_o
);

    operand_t mem_q [UB_DEPTH];

    // Host write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_o <= mem_q[raddr_i];  // One cycle read latency
    end

endmodule
